// ==== hdl/rx_packet_pkg.sv ====
`default_nettype none

package rx_packet_pkg;

    // Slot 0 carries control traffic, the remaining slots carry sample data
    localparam int unsigned NUM_SLOTS = 3;
    localparam int unsigned SLOT_W = 2;

    localparam int unsigned SAMPLE_FIFO_DEPTH = 512;
    localparam int unsigned SAMPLE_PTR_W = 9;
    localparam int unsigned USED_W = 10;

    localparam int unsigned PKT_WORDS = 256;
    localparam int unsigned HDR_WORDS = 4;
    localparam int unsigned MAX_PAYLOAD_BYTES = 504;

    localparam logic [15:0] PAD_WORD = 16'hDEAD;
    localparam logic [4:0] CTRL_CHAN_CODE = 5'h1f;

    localparam int unsigned USB_FIFO_DEPTH = 512;
    localparam int unsigned USB_PTR_W = 9;
    localparam int unsigned USB_CNT_W = 10;

    // First header word, most significant field first
    typedef struct packed {
        logic [2:0] mbz;
        logic [3:0] tag;
        logic [8:0] payload_len;
    } pkt_hdr0_t;

    typedef struct packed {
        logic       overrun;
        logic       underrun;
        logic       dropped;
        logic [1:0] burst;
        logic [5:0] rssi;
        logic [4:0] chan;
    } pkt_hdr1_t;

    typedef struct packed {
        logic        wr;
        logic [15:0] data;
    } sample_in_t;

    typedef enum logic [2:0] {
        IDLE,
        HEADER1,
        HEADER2,
        TIMESTAMP_LO,
        TIMESTAMP_HI,
        FORWARD
    } builder_state_e;

endpackage

`default_nettype wire

// ==== hdl/rx_sample_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_sample_fifo (
    input  logic                             rxclk,
    input  logic                             reset,
    input  logic                             wr,
    input  logic [15:0]                      wdata,
    input  logic                             rd,
    output logic [15:0]                      rdata,
    output logic                             empty,
    output logic [rx_packet_pkg::USED_W-1:0] used,
    output logic                             overrun,
    input  logic                             ack_flags
);

    logic [15:0] mem [rx_packet_pkg::SAMPLE_FIFO_DEPTH];

    logic [rx_packet_pkg::SAMPLE_PTR_W-1:0] wr_ptr;
    logic [rx_packet_pkg::SAMPLE_PTR_W-1:0] rd_ptr;
    logic [rx_packet_pkg::USED_W-1:0]       count;
    logic                                   full;
    logic                                   do_write;
    logic                                   do_read;
    logic                                   drop;

    assign full     = (count == rx_packet_pkg::USED_W'(rx_packet_pkg::SAMPLE_FIFO_DEPTH));
    assign empty    = (count == '0);
    assign do_write = wr && !full;
    assign do_read  = rd && !empty;
    assign drop     = wr && full;

    // Show-ahead: the head word is always visible on rdata
    assign rdata = mem[rd_ptr];
    assign used  = count;

    always_ff @(posedge rxclk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge rxclk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + rx_packet_pkg::USED_W'(do_write)
                           - rx_packet_pkg::USED_W'(do_read);

            // A drop in the ack cycle keeps the flag set for the next header
            if (drop) begin
                overrun <= 1'b1;
            end else if (ack_flags) begin
                overrun <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_rssi_meter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_rssi_meter (
    input  logic                     rxclk,
    input  logic                     reset,
    input  rx_packet_pkg::sample_in_t sample,
    input  logic                     ack_flags,
    output logic [5:0]               rssi
);

    logic [15:0] magnitude;
    logic [15:0] peak;

    // Two's complement magnitude, so full-scale negative gives 16'h8000
    always_comb begin
        if (sample.data[15]) begin
            magnitude = ~sample.data + 16'd1;
        end else begin
            magnitude = sample.data;
        end
    end

    always_ff @(posedge rxclk) begin
        if (reset) begin
            peak <= '0;
        end else if (ack_flags) begin
            // The peak restarts with the sample that arrives during the ack
            if (sample.wr) begin
                peak <= magnitude;
            end else begin
                peak <= '0;
            end
        end else if (sample.wr && (magnitude > peak)) begin
            peak <= magnitude;
        end
    end

    assign rssi = peak[14:9];

endmodule

`default_nettype wire

// ==== hdl/packet_builder.sv ====
`timescale 1ns/1ns
`default_nettype none

module packet_builder (
    input  logic                                                       rxclk,
    input  logic                                                       reset,
    input  logic [31:0]                                                adctime,
    input  logic [rx_packet_pkg::SLOT_W-1:0]                           last_slot,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0][15:0]                  chan_data,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0]                        chan_empty,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0][rx_packet_pkg::USED_W-1:0] chan_used,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0]                        chan_overrun,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0]                        underrun,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0][5:0]                   rssi,
    output logic [rx_packet_pkg::NUM_SLOTS-1:0]                        chan_rdreq,
    output logic [rx_packet_pkg::NUM_SLOTS-1:0]                        ack_flags,
    output logic                                                       wr,
    output logic [15:0]                                                fifodata,
    input  logic                                                       have_space
);

    rx_packet_pkg::builder_state_e state;

    logic [rx_packet_pkg::SLOT_W-1:0] scan_ptr;
    logic [rx_packet_pkg::SLOT_W-1:0] sel;
    logic                             slot_ready;
    logic                             scan_wrap;
    logic [rx_packet_pkg::USED_W:0]   used_bytes;
    logic [8:0]                       len_now;
    logic [8:0]                       payload_len;
    logic [7:0]                       word_cnt;
    logic                             popping;
    logic                             last_word;

    rx_packet_pkg::pkt_hdr0_t hdr0;
    rx_packet_pkg::pkt_hdr1_t hdr1;

    // Slot numbers past the last physical slot are never ready
    always_comb begin
        slot_ready = 1'b0;
        if (scan_ptr < rx_packet_pkg::SLOT_W'(rx_packet_pkg::NUM_SLOTS)) begin
            slot_ready = !chan_empty[scan_ptr];
        end
    end

    assign scan_wrap = (scan_ptr == last_slot);

    assign used_bytes = {chan_used[sel], 1'b0};
    assign len_now    = (used_bytes >
                         (rx_packet_pkg::USED_W + 1)'(rx_packet_pkg::MAX_PAYLOAD_BYTES))
                        ? 9'(rx_packet_pkg::MAX_PAYLOAD_BYTES) : used_bytes[8:0];

    assign popping   = (word_cnt < payload_len[8:1]);
    assign last_word = (word_cnt ==
                        8'(rx_packet_pkg::PKT_WORDS - rx_packet_pkg::HDR_WORDS - 1));

    always_comb begin
        hdr0             = '0;
        hdr0.payload_len = len_now;

        hdr1 = '0;
        if (sel == '0) begin
            hdr1.chan = rx_packet_pkg::CTRL_CHAN_CODE;
        end else begin
            hdr1.chan     = 5'(sel - 1'b1);
            hdr1.rssi     = rssi[sel];
            hdr1.overrun  = chan_overrun[sel];
            hdr1.underrun = underrun[sel];
        end
    end

    always_ff @(posedge rxclk) begin
        if (reset) begin
            state    <= rx_packet_pkg::IDLE;
            scan_ptr <= '0;
            sel      <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                rx_packet_pkg::IDLE: begin
                    // Only start when a whole packet is guaranteed to fit
                    if (have_space) begin
                        if (slot_ready) begin
                            sel   <= scan_ptr;
                            state <= rx_packet_pkg::HEADER1;
                        end
                        scan_ptr <= scan_wrap ? '0 : scan_ptr + 1'b1;
                    end
                end
                rx_packet_pkg::HEADER1: begin
                    state <= rx_packet_pkg::HEADER2;
                end
                rx_packet_pkg::HEADER2: begin
                    state <= rx_packet_pkg::TIMESTAMP_LO;
                end
                rx_packet_pkg::TIMESTAMP_LO: begin
                    state <= rx_packet_pkg::TIMESTAMP_HI;
                end
                rx_packet_pkg::TIMESTAMP_HI: begin
                    word_cnt <= '0;
                    state    <= rx_packet_pkg::FORWARD;
                end
                rx_packet_pkg::FORWARD: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (last_word) begin
                        state <= rx_packet_pkg::IDLE;
                    end
                end
                default: begin
                    state <= rx_packet_pkg::IDLE;
                end
            endcase
        end
    end

    // The length is fixed when the first header word goes out
    always_ff @(posedge rxclk) begin
        if (state == rx_packet_pkg::HEADER1) begin
            payload_len <= len_now;
        end
    end

    always_comb begin
        wr         = 1'b1;
        fifodata   = '0;
        chan_rdreq = '0;
        ack_flags  = '0;
        case (state)
            rx_packet_pkg::HEADER1: begin
                fifodata = hdr0;
            end
            rx_packet_pkg::HEADER2: begin
                fifodata       = hdr1;
                ack_flags[sel] = 1'b1;
            end
            rx_packet_pkg::TIMESTAMP_LO: begin
                fifodata = adctime[15:0];
            end
            rx_packet_pkg::TIMESTAMP_HI: begin
                fifodata = adctime[31:16];
            end
            rx_packet_pkg::FORWARD: begin
                if (popping) begin
                    fifodata        = chan_data[sel];
                    chan_rdreq[sel] = 1'b1;
                end else begin
                    fifodata = rx_packet_pkg::PAD_WORD;
                end
            end
            default: begin
                wr = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/usb_tx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module usb_tx_fifo (
    input  logic        rxclk,
    input  logic        reset,
    input  logic        wr,
    input  logic [15:0] wdata,
    input  logic        rd,
    output logic [15:0] rdata,
    output logic        empty,
    output logic        have_space
);

    logic [15:0] mem [rx_packet_pkg::USB_FIFO_DEPTH];

    logic [rx_packet_pkg::USB_PTR_W-1:0] wr_ptr;
    logic [rx_packet_pkg::USB_PTR_W-1:0] rd_ptr;
    logic [rx_packet_pkg::USB_CNT_W-1:0] count;
    logic [rx_packet_pkg::USB_CNT_W-1:0] free;
    logic                                full;
    logic                                do_write;
    logic                                do_read;

    assign free     = rx_packet_pkg::USB_CNT_W'(rx_packet_pkg::USB_FIFO_DEPTH) - count;
    assign full     = (free == '0);
    assign empty    = (count == '0);
    assign do_write = wr && !full;
    assign do_read  = rd && !empty;

    // Room for one complete packet, so a started packet never stalls
    assign have_space = (free >= rx_packet_pkg::USB_CNT_W'(rx_packet_pkg::PKT_WORDS));

    assign rdata = mem[rd_ptr];

    always_ff @(posedge rxclk) begin
        if (do_write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge rxclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rx_packet_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_packet_top (
    input  logic                                               rxclk,
    input  logic                                               reset,
    input  rx_packet_pkg::sample_in_t [rx_packet_pkg::NUM_SLOTS-1:0] samples,
    input  logic [rx_packet_pkg::NUM_SLOTS-1:0]                underrun,
    input  logic [31:0]                                        adctime,
    input  logic [rx_packet_pkg::SLOT_W-1:0]                   last_slot,
    input  logic                                               out_rdreq,
    output logic [15:0]                                        out_data,
    output logic                                               out_empty
);

    logic [rx_packet_pkg::NUM_SLOTS-1:0][15:0]                     chan_data;
    logic [rx_packet_pkg::NUM_SLOTS-1:0]                           chan_empty;
    logic [rx_packet_pkg::NUM_SLOTS-1:0][rx_packet_pkg::USED_W-1:0] chan_used;
    logic [rx_packet_pkg::NUM_SLOTS-1:0]                           chan_overrun;
    logic [rx_packet_pkg::NUM_SLOTS-1:0][5:0]                      rssi;
    logic [rx_packet_pkg::NUM_SLOTS-1:0]                           chan_rdreq;
    logic [rx_packet_pkg::NUM_SLOTS-1:0]                           ack_flags;

    logic        usb_wr;
    logic [15:0] usb_data;
    logic        have_space;

    for (genvar i = 0; i < rx_packet_pkg::NUM_SLOTS; i++) begin : g_slot
        rx_sample_fifo sample_fifo_i (
            .rxclk     (rxclk),
            .reset     (reset),
            .wr        (samples[i].wr),
            .wdata     (samples[i].data),
            .rd        (chan_rdreq[i]),
            .rdata     (chan_data[i]),
            .empty     (chan_empty[i]),
            .used      (chan_used[i]),
            .overrun   (chan_overrun[i]),
            .ack_flags (ack_flags[i])
        );
    end

    // The control slot has no signal strength
    assign rssi[0] = '0;

    for (genvar i = 1; i < rx_packet_pkg::NUM_SLOTS; i++) begin : g_rssi
        rx_rssi_meter rssi_meter_i (
            .rxclk     (rxclk),
            .reset     (reset),
            .sample    (samples[i]),
            .ack_flags (ack_flags[i]),
            .rssi      (rssi[i])
        );
    end

    packet_builder packet_builder_i (
        .rxclk        (rxclk),
        .reset        (reset),
        .adctime      (adctime),
        .last_slot    (last_slot),
        .chan_data    (chan_data),
        .chan_empty   (chan_empty),
        .chan_used    (chan_used),
        .chan_overrun (chan_overrun),
        .underrun     (underrun),
        .rssi         (rssi),
        .chan_rdreq   (chan_rdreq),
        .ack_flags    (ack_flags),
        .wr           (usb_wr),
        .fifodata     (usb_data),
        .have_space   (have_space)
    );

    usb_tx_fifo usb_tx_fifo_i (
        .rxclk      (rxclk),
        .reset      (reset),
        .wr         (usb_wr),
        .wdata      (usb_data),
        .rd         (out_rdreq),
        .rdata      (out_data),
        .empty      (out_empty),
        .have_space (have_space)
    );

endmodule

`default_nettype wire

// ==== tests/rx_packet_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_packet_tb;

    typedef struct packed {
        logic [3:0]  group;
        logic [1:0]  slot;
        logic [9:0]  count;
        logic        underrun;
        logic [31:0] adctime;
        logic        overfill;
        logic        hold;
    } row_t;

    localparam int NUM_ROWS = 11;
    localparam int NUM_GROUPS = 8;
    localparam int WAIT_LIMIT = 4000;

    logic                                                     rxclk;
    logic                                                     reset;
    rx_packet_pkg::sample_in_t [rx_packet_pkg::NUM_SLOTS-1:0] samples;
    logic [rx_packet_pkg::NUM_SLOTS-1:0]                      underrun;
    logic [31:0]                                              adctime;
    logic [rx_packet_pkg::SLOT_W-1:0]                         last_slot;
    logic                                                     out_rdreq;
    logic [15:0]                                              out_data;
    logic                                                     out_empty;

    row_t        rows [NUM_ROWS];
    logic [15:0] lfsr_state;
    int          mismatches;
    int          packet_no;

    // Software model of each sample FIFO and of the header flags
    logic [15:0] model_mem [3][1024];
    int          model_head [3];
    int          model_tail [3];
    logic        model_ovr [3];
    logic        model_und [3];
    logic [15:0] model_peak [3];
    logic [31:0] model_time;

    rx_packet_top rx_packet_top_i (
        .rxclk     (rxclk),
        .reset     (reset),
        .samples   (samples),
        .underrun  (underrun),
        .adctime   (adctime),
        .last_slot (last_slot),
        .out_rdreq (out_rdreq),
        .out_data  (out_data),
        .out_empty (out_empty)
    );

    always #2 rxclk = ~rxclk;

    // Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit taken
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [15:0] next_sample();
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] magnitude(input logic [15:0] d);
        int v;
        v = $signed(d);
        if (v < 0) begin
            v = -v;
        end
        return 16'(v);
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors: %0d mismatches, 1 timeout", mismatches);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic load_row(input int r);
        int          n;
        int          s;
        logic [15:0] v;
        s = rows[r].slot;
        n = rows[r].overfill ? rx_packet_pkg::SAMPLE_FIFO_DEPTH + 8 : rows[r].count;
        @(posedge rxclk);
        adctime     <= rows[r].adctime;
        underrun[s] <= rows[r].underrun;
        model_time   = rows[r].adctime;
        model_und[s] = (s == 0) ? 1'b0 : rows[r].underrun;
        for (int i = 0; i < n; i++) begin
            v = next_sample();
            @(posedge rxclk);
            samples[s] <= '{wr: 1'b1, data: v};
            if (model_tail[s] - model_head[s] < rx_packet_pkg::SAMPLE_FIFO_DEPTH) begin
                model_mem[s][model_tail[s] % 1024] = v;
                model_tail[s]++;
            end else begin
                model_ovr[s] = 1'b1;
            end
            if (magnitude(v) > model_peak[s]) begin
                model_peak[s] = magnitude(v);
            end
        end
        @(posedge rxclk);
        samples[s].wr <= 1'b0;
    endtask

    task automatic read_word(output logic [15:0] w);
        int t;
        t = 0;
        @(negedge rxclk);
        while (out_empty) begin
            @(negedge rxclk);
            t++;
            if (t > WAIT_LIMIT) begin
                report_timeout("a word from the USB FIFO");
            end
        end
        w = out_data;
        @(posedge rxclk);
        out_rdreq <= 1'b1;
        @(posedge rxclk);
        out_rdreq <= 1'b0;
    endtask

    task automatic drain_packet(input int s);
        logic [15:0]              w [rx_packet_pkg::PKT_WORDS];
        int                       n;
        rx_packet_pkg::pkt_hdr0_t h0;
        rx_packet_pkg::pkt_hdr1_t h1;
        string                    name;
        for (int i = 0; i < rx_packet_pkg::PKT_WORDS; i++) begin
            read_word(w[i]);
        end
        n = model_tail[s] - model_head[s];
        if (n > (rx_packet_pkg::MAX_PAYLOAD_BYTES / 2)) begin
            n = rx_packet_pkg::MAX_PAYLOAD_BYTES / 2;
        end
        h0 = '0;
        h0.payload_len = 9'(2 * n);
        h1 = '0;
        if (s == 0) begin
            h1.chan = rx_packet_pkg::CTRL_CHAN_CODE;
        end else begin
            h1.chan     = 5'(s - 1);
            h1.overrun  = model_ovr[s];
            h1.underrun = model_und[s];
            h1.rssi     = model_peak[s][14:9];
        end
        model_ovr[s]  = 1'b0;
        model_peak[s] = '0;
        check_value($sformatf("packet %0d hdr0", packet_no), h0, w[0]);
        check_value($sformatf("packet %0d hdr1", packet_no), h1, w[1]);
        check_value($sformatf("packet %0d time lo", packet_no), model_time[15:0], w[2]);
        check_value($sformatf("packet %0d time hi", packet_no), model_time[31:16], w[3]);
        for (int i = rx_packet_pkg::HDR_WORDS; i < rx_packet_pkg::PKT_WORDS; i++) begin
            name = $sformatf("packet %0d word %0d", packet_no, i);
            if (i - rx_packet_pkg::HDR_WORDS < n) begin
                check_value(name, model_mem[s][model_head[s] % 1024], w[i]);
                model_head[s]++;
            end else begin
                check_value(name, rx_packet_pkg::PAD_WORD, w[i]);
            end
        end
        packet_no++;
    endtask

    task automatic run_group(input int g);
        logic hold;
        int   ptr;
        int   s;
        hold = 1'b0;
        // Scanning only slot 0 keeps the data slots idle while they fill
        @(posedge rxclk);
        last_slot <= '0;
        repeat (4) @(posedge rxclk);
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (rows[r].group == g) begin
                load_row(r);
                hold |= rows[r].hold;
            end
        end
        @(posedge rxclk);
        last_slot <= 2'd2;
        if (hold) begin
            repeat (700) @(posedge rxclk);
        end
        ptr = 0;
        while (model_tail[0] > model_head[0] || model_tail[1] > model_head[1] ||
               model_tail[2] > model_head[2]) begin
            s = ptr;
            for (int k = 0; k < 3; k++) begin
                if (model_tail[(ptr + k) % 3] == model_head[(ptr + k) % 3]) begin
                    s = (ptr + k + 1) % 3;
                end else begin
                    break;
                end
            end
            drain_packet(s);
            ptr = (s + 1) % 3;
        end
    endtask

    initial begin
        rxclk      = 1'b0;
        reset      = 1'b1;
        samples    = '0;
        underrun   = '0;
        adctime    = '0;
        last_slot  = 2'd2;
        out_rdreq  = 1'b0;
        lfsr_state = 16'd50777;
        mismatches = 0;
        packet_no  = 0;
        model_time = '0;
        for (int s = 0; s < 3; s++) begin
            model_head[s] = 0;
            model_tail[s] = 0;
            model_ovr[s]  = 1'b0;
            model_und[s]  = 1'b0;
            model_peak[s] = '0;
        end

        // group, slot, count, underrun, adctime, overfill, hold
        rows[0]  = '{4'd0, 2'd1, 10'd40,  1'b0, 32'h0000_1000, 1'b0, 1'b0};
        rows[1]  = '{4'd1, 2'd2, 10'd300, 1'b1, 32'h1234_5678, 1'b0, 1'b0};
        rows[2]  = '{4'd2, 2'd0, 10'd1,   1'b1, 32'hcafe_0001, 1'b0, 1'b0};
        rows[3]  = '{4'd2, 2'd1, 10'd20,  1'b1, 32'hcafe_0001, 1'b0, 1'b0};
        rows[4]  = '{4'd3, 2'd1, 10'd300, 1'b0, 32'h0bad_f00d, 1'b0, 1'b0};
        rows[5]  = '{4'd3, 2'd2, 10'd300, 1'b0, 32'h0bad_f00d, 1'b0, 1'b0};
        rows[6]  = '{4'd4, 2'd2, 10'd0,   1'b0, 32'h8000_0042, 1'b1, 1'b0};
        rows[7]  = '{4'd5, 2'd1, 10'd0,   1'b1, 32'h7fff_ffff, 1'b1, 1'b1};
        rows[8]  = '{4'd6, 2'd2, 10'd10,  1'b1, 32'h0000_0003, 1'b0, 1'b0};
        rows[9]  = '{4'd6, 2'd1, 10'd252, 1'b0, 32'h0000_0003, 1'b0, 1'b0};
        rows[10] = '{4'd7, 2'd0, 10'd1,   1'b0, 32'hffff_0000, 1'b0, 1'b0};

        repeat (4) @(posedge rxclk);
        reset <= 1'b0;

        for (int g = 0; g < NUM_GROUPS; g++) begin
            run_group(g);
        end

        // Nothing may follow the last expected packet
        repeat (300) @(posedge rxclk);
        @(negedge rxclk);
        check_value("no extra words", 16'd1, {15'd0, out_empty});

        $display("Errors: %0d mismatches, 0 timeouts, %0d packets", mismatches, packet_no);
        if (mismatches == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/rx_packet_pkg.sv
hdl/rx_sample_fifo.sv
hdl/rx_rssi_meter.sv
hdl/packet_builder.sv
hdl/usb_tx_fifo.sv
hdl/rx_packet_top.sv
tests/rx_packet_tb.sv

// ==== Bender.yml ====
package:
  name: rx_packet

sources:
  - files:
      - hdl/rx_packet_pkg.sv
      - hdl/rx_sample_fifo.sv
      - hdl/rx_rssi_meter.sv
      - hdl/packet_builder.sv
      - hdl/usb_tx_fifo.sv
      - hdl/rx_packet_top.sv
  - target: test
    files:
      - tests/rx_packet_tb.sv
